/* include/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Address widths for Sv39
`define MMU_VA_W   39
`define MMU_PA_W   40
`define MMU_VPN_W  27
`define MMU_PPN_W  28
`define MMU_OFS_W  12

// VPN slice per walk level
`define MMU_LVL_W  9

// TLB sizes
`define MMU_UTLB_ENTRIES  4
`define MMU_JTLB_ENTRIES  64

`endif

/* rtl/mmu_pkg.sv */
`include "mmu_config.svh"

package mmu_pkg;

  // ========================================
  // Address and entry types
  // ========================================
  typedef logic [`MMU_VA_W-1:0]  va_t;
  typedef logic [`MMU_PA_W-1:0]  pa_t;
  typedef logic [`MMU_VPN_W-1:0] vpn_t;
  typedef logic [`MMU_PPN_W-1:0] ppn_t;

  // Raw Sv39 page-table entry
  typedef logic [63:0] pte_t;

  // Bit 0 R, bit 1 W, bit 2 X, same order as PTE bits 3:1
  typedef logic [2:0] perm_t;

  // ========================================
  // State machines
  // ========================================
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IUTLB,
    ARB_DUTLB
  } arb_state_t;

  typedef enum logic [1:0] {
    PTW_IDLE,
    PTW_REQ,
    PTW_WAIT,
    PTW_DONE
  } ptw_state_t;

endpackage

/* rtl/mmu_utlb.sv */
`include "mmu_config.svh"

module mmu_utlb #(
  parameter int ENTRIES = `MMU_UTLB_ENTRIES
) (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  logic           mmu_en,
  input  logic           tlb_flush,
  input  logic           va_vld,
  input  mmu_pkg::va_t   va,
  input  logic           st_inst,
  input  logic           exec,
  output logic           pa_vld,
  output mmu_pkg::pa_t   pa,
  output logic           page_fault,
  output logic           arb_req,
  output mmu_pkg::vpn_t  arb_vpn,
  input  logic           arb_grant,
  input  logic           ref_cmplt,
  input  mmu_pkg::ppn_t  ref_ppn,
  input  mmu_pkg::perm_t ref_perm,
  input  logic           ref_fault
);
  import mmu_pkg::*;

  localparam int PTR_W = $clog2(ENTRIES);

  logic [ENTRIES-1:0] ent_vld;
  vpn_t               ent_vpn  [ENTRIES];
  ppn_t               ent_ppn  [ENTRIES];
  perm_t              ent_perm [ENTRIES];
  logic [PTR_W-1:0]   rr_ptr;

  vpn_t  va_vpn;
  logic  hit;
  ppn_t  hit_ppn;
  perm_t hit_perm;
  logic  perm_ok;
  logic  refill_ok;

  assign va_vpn  = va[`MMU_VA_W-1:`MMU_OFS_W];
  assign arb_vpn = va_vpn;

  // ========================================
  // Lookup
  // ========================================
  always_comb begin
    hit      = 1'b0;
    hit_ppn  = '0;
    hit_perm = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (ent_vld[i] && (ent_vpn[i] == va_vpn)) begin
        hit      = 1'b1;
        hit_ppn  = ent_ppn[i];
        hit_perm = ent_perm[i];
      end
    end
  end

  // Fetch needs X, store needs W, load needs R
  assign perm_ok = exec ? hit_perm[2] : (st_inst ? hit_perm[1] : hit_perm[0]);

  assign refill_ok = arb_req && arb_grant && ref_cmplt && !ref_fault;

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      pa_vld     <= 1'b0;
      page_fault <= 1'b0;
      arb_req    <= 1'b0;
      ent_vld    <= '0;
      rr_ptr     <= '0;
    end else begin
      pa_vld     <= 1'b0;
      page_fault <= 1'b0;
      if (tlb_flush) begin
        ent_vld <= '0;
      end else if (refill_ok) begin
        ent_vld[rr_ptr] <= 1'b1;
        rr_ptr          <= (rr_ptr == PTR_W'(ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
      end
      if (arb_req) begin
        if (arb_grant && ref_cmplt) begin
          arb_req <= 1'b0;
          // A good refill is replayed as a lookup next cycle
          if (ref_fault) begin
            pa_vld     <= 1'b1;
            page_fault <= 1'b1;
          end
        end
      end else if (va_vld && !pa_vld) begin
        if (!mmu_en || hit) begin
          pa_vld     <= 1'b1;
          page_fault <= mmu_en && !perm_ok;
        end else begin
          arb_req <= 1'b1;
        end
      end
    end
  end

  // Entry payload and result address
  always_ff @(posedge forever_cpuclk) begin
    if (!mmu_en) begin
      pa <= {{(`MMU_PA_W - `MMU_VA_W){1'b0}}, va};
    end else begin
      pa <= {hit_ppn, va[`MMU_OFS_W-1:0]};
    end
    if (refill_ok) begin
      ent_vpn[rr_ptr]  <= va_vpn;
      ent_ppn[rr_ptr]  <= ref_ppn;
      ent_perm[rr_ptr] <= ref_perm;
    end
  end

endmodule

/* rtl/mmu_arb.sv */
module mmu_arb (
  input  logic          forever_cpuclk,
  input  logic          rst,
  input  logic          iutlb_req,
  input  mmu_pkg::vpn_t iutlb_vpn,
  input  logic          dutlb_req,
  input  mmu_pkg::vpn_t dutlb_vpn,
  input  logic          ref_cmplt,
  output logic          iutlb_grant,
  output logic          dutlb_grant,
  output logic          jtlb_req,
  output mmu_pkg::vpn_t jtlb_vpn
);
  import mmu_pkg::*;

  arb_state_t state;
  arb_state_t state_nxt;

  // Load/store side wins from idle
  always_comb begin
    state_nxt = state;
    case (state)
      ARB_IDLE: begin
        if (dutlb_req) begin
          state_nxt = ARB_DUTLB;
        end else if (iutlb_req) begin
          state_nxt = ARB_IUTLB;
        end
      end
      ARB_IUTLB,
      ARB_DUTLB: begin
        if (ref_cmplt) begin
          state_nxt = ARB_IDLE;
        end
      end
      default: state_nxt = ARB_IDLE;
    endcase
  end

  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      state    <= ARB_IDLE;
      jtlb_req <= 1'b0;
    end else begin
      state    <= state_nxt;
      jtlb_req <= (state == ARB_IDLE) && (state_nxt != ARB_IDLE);
    end
  end

  assign iutlb_grant = (state == ARB_IUTLB);
  assign dutlb_grant = (state == ARB_DUTLB);
  assign jtlb_vpn    = dutlb_grant ? dutlb_vpn : iutlb_vpn;

endmodule

/* rtl/mmu_jtlb.sv */
`include "mmu_config.svh"

module mmu_jtlb #(
  parameter int ENTRIES = `MMU_JTLB_ENTRIES
) (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  logic           tlb_flush,
  input  logic           req,
  input  mmu_pkg::vpn_t  vpn,
  input  logic           ptw_cmplt,
  input  mmu_pkg::ppn_t  ptw_ppn,
  input  mmu_pkg::perm_t ptw_perm,
  input  logic           ptw_fault,
  output logic           ptw_req,
  output mmu_pkg::vpn_t  ptw_vpn,
  output logic           ref_cmplt,
  output mmu_pkg::ppn_t  ref_ppn,
  output mmu_pkg::perm_t ref_perm,
  output logic           ref_fault
);
  import mmu_pkg::*;

  // ENTRIES is a power of two
  localparam int IDX_W = $clog2(ENTRIES);
  localparam int TAG_W = `MMU_VPN_W - IDX_W;

  logic [ENTRIES-1:0] ent_vld;
  logic [TAG_W-1:0]   ent_tag  [ENTRIES];
  ppn_t               ent_ppn  [ENTRIES];
  perm_t              ent_perm [ENTRIES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             hit;
  logic             fill;

  // The arbiter holds vpn until ref_cmplt, so the walk can use it as is
  assign idx     = vpn[IDX_W-1:0];
  assign tag     = vpn[`MMU_VPN_W-1:IDX_W];
  assign hit     = ent_vld[idx] && (ent_tag[idx] == tag);
  assign fill    = ptw_cmplt && !ptw_fault;
  assign ptw_vpn = vpn;

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      ent_vld   <= '0;
      ptw_req   <= 1'b0;
      ref_cmplt <= 1'b0;
    end else begin
      ptw_req   <= req && !hit;
      ref_cmplt <= (req && hit) || ptw_cmplt;
      if (tlb_flush) begin
        ent_vld <= '0;
      end else if (fill) begin
        ent_vld[idx] <= 1'b1;
      end
    end
  end

  // Walker result forwarded, otherwise the indexed entry
  always_ff @(posedge forever_cpuclk) begin
    if (ptw_cmplt) begin
      ref_ppn   <= ptw_ppn;
      ref_perm  <= ptw_perm;
      ref_fault <= ptw_fault;
    end else begin
      ref_ppn   <= ent_ppn[idx];
      ref_perm  <= ent_perm[idx];
      ref_fault <= 1'b0;
    end
    if (fill) begin
      ent_tag[idx]  <= tag;
      ent_ppn[idx]  <= ptw_ppn;
      ent_perm[idx] <= ptw_perm;
    end
  end

endmodule

/* rtl/mmu_ptw.sv */
`include "mmu_config.svh"

module mmu_ptw (
  input  logic           forever_cpuclk,
  input  logic           rst,
  input  mmu_pkg::ppn_t  satp_ppn,
  input  logic           req,
  input  mmu_pkg::vpn_t  vpn,
  input  logic           mem_data_vld,
  input  mmu_pkg::pte_t  mem_data,
  output logic           cmplt,
  output mmu_pkg::ppn_t  ppn,
  output mmu_pkg::perm_t perm,
  output logic           fault,
  output logic           mem_req,
  output mmu_pkg::pa_t   mem_addr
);
  import mmu_pkg::*;

  localparam int L = `MMU_LVL_W;

  ptw_state_t state;
  logic [1:0] lvl;
  ppn_t       table_ppn;
  vpn_t       vpn_q;

  logic [L-1:0] slice;
  ppn_t         pte_ppn;
  ppn_t         leaf_ppn;
  logic         pte_bad;
  logic         pte_leaf;
  logic         walk_end;

  // ========================================
  // PTE decode
  // ========================================
  assign pte_ppn  = mem_data[`MMU_PPN_W+9:10];
  // V clear, or W without R
  assign pte_bad  = !mem_data[0] || (mem_data[2] && !mem_data[1]);
  assign pte_leaf = mem_data[1] || mem_data[3];
  assign walk_end = pte_bad || pte_leaf || (lvl == 2'd0);

  // Superpages take their low PPN slices from the VPN
  always_comb begin
    case (lvl)
      2'd2: begin
        slice    = vpn_q[3*L-1:2*L];
        leaf_ppn = {pte_ppn[`MMU_PPN_W-1:2*L], vpn_q[2*L-1:0]};
      end
      2'd1: begin
        slice    = vpn_q[2*L-1:L];
        leaf_ppn = {pte_ppn[`MMU_PPN_W-1:L], vpn_q[L-1:0]};
      end
      default: begin
        slice    = vpn_q[L-1:0];
        leaf_ppn = pte_ppn;
      end
    endcase
  end

  // ========================================
  // Walk FSM
  // ========================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      state <= PTW_IDLE;
    end else begin
      case (state)
        PTW_IDLE: begin
          if (req) begin
            state <= PTW_REQ;
          end
        end
        PTW_REQ:  state <= PTW_WAIT;
        PTW_WAIT: begin
          if (mem_data_vld) begin
            state <= walk_end ? PTW_DONE : PTW_REQ;
          end
        end
        default:  state <= PTW_IDLE;
      endcase
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if ((state == PTW_IDLE) && req) begin
      vpn_q     <= vpn;
      table_ppn <= satp_ppn;
      lvl       <= 2'd2;
    end
    if ((state == PTW_WAIT) && mem_data_vld) begin
      table_ppn <= pte_ppn;
      lvl       <= lvl - 2'd1;
      ppn       <= leaf_ppn;
      perm      <= mem_data[3:1];
      fault     <= pte_bad || (!pte_leaf && (lvl == 2'd0));
    end
  end

  // Entry address is table base plus 8 times the slice
  assign mem_req  = (state == PTW_REQ);
  assign mem_addr = {table_ppn, slice, 3'b000};
  assign cmplt    = (state == PTW_DONE);

endmodule

/* rtl/mmu_top.sv */
module mmu_top (
  input  logic          forever_cpuclk,
  input  logic          rst,
  input  logic          mmu_en,
  input  mmu_pkg::ppn_t satp_ppn,
  input  logic          tlb_flush,
  input  logic          ifu_va_vld,
  input  mmu_pkg::va_t  ifu_va,
  output logic          ifu_pa_vld,
  output mmu_pkg::pa_t  ifu_pa,
  output logic          ifu_page_fault,
  input  logic          lsu_va_vld,
  input  mmu_pkg::va_t  lsu_va,
  input  logic          lsu_st_inst,
  output logic          lsu_pa_vld,
  output mmu_pkg::pa_t  lsu_pa,
  output logic          lsu_page_fault,
  output logic          mem_req,
  output mmu_pkg::pa_t  mem_addr,
  input  logic          mem_data_vld,
  input  mmu_pkg::pte_t mem_data
);
  import mmu_pkg::*;

  logic  iutlb_arb_req;
  vpn_t  iutlb_arb_vpn;
  logic  dutlb_arb_req;
  vpn_t  dutlb_arb_vpn;
  logic  arb_iutlb_grant;
  logic  arb_dutlb_grant;
  logic  arb_jtlb_req;
  vpn_t  arb_jtlb_vpn;
  logic  jtlb_ptw_req;
  vpn_t  jtlb_ptw_vpn;
  logic  ptw_jtlb_cmplt;
  ppn_t  ptw_jtlb_ppn;
  perm_t ptw_jtlb_perm;
  logic  ptw_jtlb_fault;
  logic  ref_cmplt;
  ppn_t  ref_ppn;
  perm_t ref_perm;
  logic  ref_fault;

  // ========================================
  // Micro-TLBs
  // ========================================
  mmu_utlb iutlb_i (
    .forever_cpuclk,
    .rst,
    .mmu_en,
    .tlb_flush,
    .va_vld     (ifu_va_vld),
    .va         (ifu_va),
    .st_inst    (1'b0),
    .exec       (1'b1),
    .pa_vld     (ifu_pa_vld),
    .pa         (ifu_pa),
    .page_fault (ifu_page_fault),
    .arb_req    (iutlb_arb_req),
    .arb_vpn    (iutlb_arb_vpn),
    .arb_grant  (arb_iutlb_grant),
    .ref_cmplt,
    .ref_ppn,
    .ref_perm,
    .ref_fault
  );

  mmu_utlb dutlb_i (
    .forever_cpuclk,
    .rst,
    .mmu_en,
    .tlb_flush,
    .va_vld     (lsu_va_vld),
    .va         (lsu_va),
    .st_inst    (lsu_st_inst),
    .exec       (1'b0),
    .pa_vld     (lsu_pa_vld),
    .pa         (lsu_pa),
    .page_fault (lsu_page_fault),
    .arb_req    (dutlb_arb_req),
    .arb_vpn    (dutlb_arb_vpn),
    .arb_grant  (arb_dutlb_grant),
    .ref_cmplt,
    .ref_ppn,
    .ref_perm,
    .ref_fault
  );

  // ========================================
  // Shared path
  // ========================================
  mmu_arb arb_i (
    .forever_cpuclk,
    .rst,
    .iutlb_req   (iutlb_arb_req),
    .iutlb_vpn   (iutlb_arb_vpn),
    .dutlb_req   (dutlb_arb_req),
    .dutlb_vpn   (dutlb_arb_vpn),
    .ref_cmplt,
    .iutlb_grant (arb_iutlb_grant),
    .dutlb_grant (arb_dutlb_grant),
    .jtlb_req    (arb_jtlb_req),
    .jtlb_vpn    (arb_jtlb_vpn)
  );

  mmu_jtlb jtlb_i (
    .forever_cpuclk,
    .rst,
    .tlb_flush,
    .req       (arb_jtlb_req),
    .vpn       (arb_jtlb_vpn),
    .ptw_cmplt (ptw_jtlb_cmplt),
    .ptw_ppn   (ptw_jtlb_ppn),
    .ptw_perm  (ptw_jtlb_perm),
    .ptw_fault (ptw_jtlb_fault),
    .ptw_req   (jtlb_ptw_req),
    .ptw_vpn   (jtlb_ptw_vpn),
    .ref_cmplt,
    .ref_ppn,
    .ref_perm,
    .ref_fault
  );

  mmu_ptw ptw_i (
    .forever_cpuclk,
    .rst,
    .satp_ppn,
    .req          (jtlb_ptw_req),
    .vpn          (jtlb_ptw_vpn),
    .mem_data_vld,
    .mem_data,
    .cmplt        (ptw_jtlb_cmplt),
    .ppn          (ptw_jtlb_ppn),
    .perm         (ptw_jtlb_perm),
    .fault        (ptw_jtlb_fault),
    .mem_req,
    .mem_addr
  );

endmodule

/* verif/mmu_tb.sv */
module mmu_tb;
  import mmu_pkg::*;

  localparam int   TEST_COUNT = 23;
  // Edges from driving va_vld to seeing the pa_vld strobe
  localparam int   HIT_LAT    = 2;
  localparam ppn_t PT_BASE    = 28'h80000;

  // PTE flag nibbles as X W R V
  localparam logic [3:0] F_PTR = 4'b0001;
  localparam logic [3:0] F_RWX = 4'b1111;
  localparam logic [3:0] F_RW  = 4'b0111;
  localparam logic [3:0] F_R   = 4'b0011;
  localparam logic [3:0] F_X   = 4'b1001;
  localparam logic [3:0] F_W   = 4'b0101;
  localparam logic [3:0] F_RX  = 4'b1011;

  logic forever_cpuclk;
  logic rst;
  logic mmu_en;
  ppn_t satp_ppn;
  logic tlb_flush;
  logic ifu_va_vld;
  va_t  ifu_va;
  logic ifu_pa_vld;
  pa_t  ifu_pa;
  logic ifu_page_fault;
  logic lsu_va_vld;
  va_t  lsu_va;
  logic lsu_st_inst;
  logic lsu_pa_vld;
  pa_t  lsu_pa;
  logic lsu_page_fault;
  logic mem_req;
  pa_t  mem_addr;
  logic mem_data_vld;
  pte_t mem_data;

  pte_t        pt_mem [pa_t];
  logic [40:0] ifu_exp_q [$];
  logic [40:0] lsu_exp_q [$];
  logic [40:0] ifu_exp;
  logic [40:0] lsu_exp;
  pa_t         mem_addr_q;
  integer      seed;
  int          mem_rnd;
  int          mem_delay;
  int          mem_req_count;
  int          reqs_before;
  int          error_count;
  int          check_count;
  int          ifu_lat;
  int          lsu_lat;

  mmu_top dut_i (.*);

  always #10 forever_cpuclk = ~forever_cpuclk;

  // ========================================
  // Helpers
  // ========================================
  function automatic pte_t make_pte(input ppn_t ppn, input logic [3:0] flags);
    return {26'h0, ppn, 6'h00, flags};
  endfunction

  function automatic pa_t pte_addr(input ppn_t tbl, input logic [8:0] idx);
    return {tbl, idx, 3'b000};
  endfunction

  function automatic pte_t read_pte(input pa_t addr);
    return pt_mem.exists(addr) ? pt_mem[addr] : 64'h0;
  endfunction

  // Random page offset on top of the three VPN slices
  function automatic va_t va_at(input logic [8:0] v2, input logic [8:0] v1,
                                input logic [8:0] v0);
    int r;
    r = $random(seed);
    return {v2, v1, v0, r[11:0]};
  endfunction

  function automatic void ref_translate(input logic en, input va_t va, input bit exec,
                                        input logic store, output pa_t pa,
                                        output logic fault);
    ppn_t       tbl;
    ppn_t       leaf;
    pte_t       pte;
    logic [8:0] idx;
    pa    = {1'b0, va};
    fault = 1'b0;
    if (!en) return;
    tbl = PT_BASE;
    for (int lvl = 2; lvl >= 0; lvl--) begin
      idx = va[12 + 9*lvl +: 9];
      pte = read_pte(pte_addr(tbl, idx));
      if (!pte[0] || (pte[2] && !pte[1])) begin
        fault = 1'b1;
        return;
      end
      if (pte[1] || pte[3]) begin
        leaf = pte[37:10];
        for (int i = 0; i < lvl; i++) begin
          leaf[9*i +: 9] = va[12 + 9*i +: 9];
        end
        pa    = {leaf, va[11:0]};
        fault = exec ? !pte[3] : (store ? !pte[2] : !pte[1]);
        return;
      end
      tbl = pte[37:10];
    end
    // Pointer found at level 0
    fault = 1'b1;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at time %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic compare_result(input string port, input pa_t got_pa, input logic got_fault,
                                input logic [40:0] exp);
    check_value({port, " page_fault"}, got_fault, exp[40]);
    if (!exp[40]) begin
      check_value({port, " pa"}, got_pa, exp[39:0]);
    end
  endtask

  task automatic build_tables;
    pt_mem[pte_addr(PT_BASE, 9'd1)]          = make_pte(PT_BASE + 28'd1, F_PTR);
    pt_mem[pte_addr(PT_BASE, 9'd2)]          = make_pte(28'h40000, F_RX);
    pt_mem[pte_addr(PT_BASE + 28'd1, 9'd0)]  = make_pte(PT_BASE + 28'd2, F_PTR);
    pt_mem[pte_addr(PT_BASE + 28'd1, 9'd1)]  = make_pte(28'h00a00, F_RWX);
    // Entry 3 of the leaf table has RWX with V clear
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd0)]  = make_pte(28'h00100, F_RWX);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd1)]  = make_pte(28'h00200, F_R);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd2)]  = make_pte(28'h00300, F_X);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd3)]  = make_pte(28'h00333, 4'b1110);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd4)]  = make_pte(28'h00400, F_RW);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd5)]  = make_pte(28'h00500, F_W);
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd6)]  = make_pte(28'h00600, F_PTR);
  endtask

  // Issue one request and hold it until the result strobe
  task automatic run_access(input bit on_lsu, input va_t va, input logic store,
                            output int lat);
    pa_t  exp_pa;
    logic exp_fault;
    ref_translate(mmu_en, va, !on_lsu, store, exp_pa, exp_fault);
    lat = 0;
    if (on_lsu) begin
      lsu_exp_q.push_back({exp_fault, exp_pa});
      lsu_va_vld  <= 1'b1;
      lsu_va      <= va;
      lsu_st_inst <= store;
    end else begin
      ifu_exp_q.push_back({exp_fault, exp_pa});
      ifu_va_vld <= 1'b1;
      ifu_va     <= va;
    end
    do begin
      @(posedge forever_cpuclk);
      lat++;
    end while (!(on_lsu ? lsu_pa_vld : ifu_pa_vld));
    if (on_lsu) begin
      lsu_va_vld <= 1'b0;
    end else begin
      ifu_va_vld <= 1'b0;
    end
    @(posedge forever_cpuclk);
  endtask

  // ========================================
  // Page-table memory model
  // ========================================
  always begin
    @(posedge forever_cpuclk);
    if (!rst && mem_req) begin
      mem_addr_q    = mem_addr;
      mem_req_count = mem_req_count + 1;
      mem_rnd       = $random(seed);
      mem_delay     = 1 + mem_rnd[1:0];
      repeat (mem_delay) @(posedge forever_cpuclk);
      mem_data     <= read_pte(mem_addr_q);
      mem_data_vld <= 1'b1;
      @(posedge forever_cpuclk);
      mem_data_vld <= 1'b0;
    end
  end

  // Result checker for both ports
  always @(posedge forever_cpuclk) begin
    if (!rst && ifu_pa_vld) begin
      if (ifu_exp_q.size() == 0) begin
        error_count++;
        $display("Fetch result strobe at %0t with no request outstanding", $time);
      end else begin
        ifu_exp = ifu_exp_q.pop_front();
        compare_result("fetch", ifu_pa, ifu_page_fault, ifu_exp);
      end
    end
    if (!rst && lsu_pa_vld) begin
      if (lsu_exp_q.size() == 0) begin
        error_count++;
        $display("Load/store result strobe at %0t with no request outstanding", $time);
      end else begin
        lsu_exp = lsu_exp_q.pop_front();
        compare_result("load/store", lsu_pa, lsu_page_fault, lsu_exp);
      end
    end
  end

  initial begin
    repeat (200 * TEST_COUNT) @(posedge forever_cpuclk);
    $display("Watchdog expired, the run timed out after %0d cycles", 200 * TEST_COUNT);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    seed           = 32'h1eccddd4;
    forever_cpuclk = 1'b0;
    rst            = 1'b1;
    mmu_en         = 1'b0;
    satp_ppn       = PT_BASE;
    tlb_flush      = 1'b0;
    ifu_va_vld     = 1'b0;
    ifu_va         = '0;
    lsu_va_vld     = 1'b0;
    lsu_va         = '0;
    lsu_st_inst    = 1'b0;
    mem_data_vld   = 1'b0;
    mem_data       = '0;
    build_tables;
    repeat (3) @(posedge forever_cpuclk);
    rst <= 1'b0;
    @(posedge forever_cpuclk);

    // Bare mode
    reqs_before = mem_req_count;
    run_access(1'b0, va_at(9'h1ab, 9'h0cd, 9'h0ef), 1'b0, ifu_lat);
    check_value("bare fetch latency", ifu_lat, HIT_LAT);
    run_access(1'b1, va_at(9'h155, 9'h0aa, 9'h033), 1'b1, lsu_lat);
    check_value("bare store latency", lsu_lat, HIT_LAT);
    check_value("memory reads in bare mode", mem_req_count - reqs_before, 0);

    // 4 KiB, 2 MiB and 1 GiB mappings
    mmu_en <= 1'b1;
    @(posedge forever_cpuclk);
    run_access(1'b0, va_at(9'd1, 9'd0, 9'd0), 1'b0, ifu_lat);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd0), 1'b0, lsu_lat);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd4), 1'b1, lsu_lat);
    run_access(1'b0, va_at(9'd1, 9'd1, 9'h037), 1'b0, ifu_lat);
    run_access(1'b1, va_at(9'd2, 9'h055, 9'h012), 1'b0, lsu_lat);
    run_access(1'b0, va_at(9'd2, 9'h055, 9'h012), 1'b0, ifu_lat);

    // Micro-TLB hits
    reqs_before = mem_req_count;
    run_access(1'b0, va_at(9'd1, 9'd0, 9'd0), 1'b0, ifu_lat);
    check_value("fetch hit latency", ifu_lat, HIT_LAT);
    run_access(1'b1, va_at(9'd2, 9'h055, 9'h012), 1'b0, lsu_lat);
    check_value("load hit latency", lsu_lat, HIT_LAT);
    check_value("memory reads on micro-TLB hits", mem_req_count - reqs_before, 0);

    // Page faults
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd3), 1'b0, lsu_lat);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd5), 1'b0, lsu_lat);
    run_access(1'b0, va_at(9'd1, 9'd0, 9'd6), 1'b0, ifu_lat);
    run_access(1'b0, va_at(9'd1, 9'd0, 9'd1), 1'b0, ifu_lat);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd1), 1'b1, lsu_lat);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd2), 1'b0, lsu_lat);
    run_access(1'b1, va_at(9'd3, 9'd0, 9'd0), 1'b0, lsu_lat);

    // Remap page 1, held read-only by both micro-TLBs, and flush
    pt_mem[pte_addr(PT_BASE + 28'd2, 9'd1)] = make_pte(28'h00777, F_RWX);
    tlb_flush <= 1'b1;
    @(posedge forever_cpuclk);
    tlb_flush <= 1'b0;
    reqs_before = mem_req_count;
    run_access(1'b0, va_at(9'd1, 9'd0, 9'd1), 1'b0, ifu_lat);
    check_value("memory reads after flush", mem_req_count - reqs_before, 3);
    run_access(1'b1, va_at(9'd1, 9'd0, 9'd1), 1'b1, lsu_lat);

    // Misses on both ports in the same cycle
    fork
      run_access(1'b0, va_at(9'd1, 9'd1, 9'h101), 1'b0, ifu_lat);
      run_access(1'b1, va_at(9'd1, 9'd0, 9'd4), 1'b1, lsu_lat);
    join
    fork
      run_access(1'b0, va_at(9'd1, 9'd0, 9'd2), 1'b0, ifu_lat);
      run_access(1'b1, va_at(9'd1, 9'd0, 9'd5), 1'b1, lsu_lat);
    join

    if (ifu_exp_q.size() != 0 || lsu_exp_q.size() != 0) begin
      error_count++;
      $display("Some requests ended without a checked result");
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
rtl/mmu_pkg.sv
rtl/mmu_utlb.sv
rtl/mmu_arb.sv
rtl/mmu_jtlb.sv
rtl/mmu_ptw.sv
rtl/mmu_top.sv
verif/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu

export_include_dirs:
  - include

sources:
  - rtl/mmu_pkg.sv
  - rtl/mmu_utlb.sv
  - rtl/mmu_arb.sv
  - rtl/mmu_jtlb.sv
  - rtl/mmu_ptw.sv
  - rtl/mmu_top.sv
  - target: test
    files:
      - verif/mmu_tb.sv
